// File: verilog/deskew_macros.svh
// shared constants for the lane deskew block, included by the RTL that needs taps or offsets
`ifndef DESKEW_MACROS_SVH
`define DESKEW_MACROS_SVH

// first fine step that is out of range, also fine steps per coarse tap
`define DESKEW_FINE_LIMIT 5

// tap line length, covers coarse 31 * 5 + fine 4
`define DESKEW_MAX_TAPS 160

// agreeing cycles needed before lock
`define DESKEW_LOCK_RUN 32

// axi4-lite register byte offsets
`define DESKEW_REG_LANE0  4'h0
`define DESKEW_REG_LANE1  4'h4
`define DESKEW_REG_CTRL   4'h8
`define DESKEW_REG_STATUS 4'hC

`endif

// File: verilog/deskew_pkg.sv
// types shared by the deskew RTL, imported by each module that uses them
`default_nettype none

package deskew_pkg;

    // delay code, coarse taps in [7:3], fine step in [2:0]
    typedef logic [7:0] dly_t;

    // comparator mismatch count
    typedef logic [15:0] err_cnt_t;

    // axi4-lite byte address
    typedef logic [3:0] axil_addr_t;

    // per-lane control from the register block
    typedef struct packed {
        logic ld;
        logic set;
        dly_t dly;
    } dly_ctl_t;

    // comparator status back to the register block
    typedef struct packed {
        err_cnt_t count;
        logic     locked;
    } cmp_stat_t;

    // write channel: wait for aw+w, then hold the response
    typedef enum logic {
        wr_idle,
        wr_resp
    } axil_wr_state_e;

    // read channel: wait for ar, then hold the data
    typedef enum logic {
        rd_idle,
        rd_data
    } axil_rd_state_e;

endpackage

`default_nettype wire

// File: verilog/idelay_fine_pipe.sv
// one deskew lane: staged/applied delay code driving a clocked tap line, one cycle per tap
`timescale 1ns/1ps
`default_nettype none

`include "deskew_macros.svh"

module idelay_fine_pipe #(
    parameter int DELAY_VALUE = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  deskew_pkg::dly_ctl_t ctl,
    input  logic                 data_in,
    output logic                 data_out,
    output logic                 fine_err
);
    import deskew_pkg::*;

    localparam int TAP_W = $clog2(`DESKEW_MAX_TAPS);

    // fine step saturates one below the limit
    function automatic dly_t clamp_fine(input dly_t code);
        dly_t res;
        res = code;
        if (code[2:0] >= 3'(`DESKEW_FINE_LIMIT)) begin
            res[2:0] = 3'(`DESKEW_FINE_LIMIT - 1);
        end
        return res;
    endfunction

    // one coarse tap spans a full set of fine steps
    function automatic logic [TAP_W-1:0] code_taps(input dly_t code);
        return TAP_W'(code[7:3]) * TAP_W'(`DESKEW_FINE_LIMIT) + TAP_W'(code[2:0]);
    endfunction

    localparam dly_t RESET_CODE = clamp_fine(dly_t'(DELAY_VALUE));

    dly_t                        dly_pre;
    dly_t                        dly_act;
    logic [TAP_W-1:0]            tap_sel;
    logic [`DESKEW_MAX_TAPS-1:1] shift_q;
    logic [`DESKEW_MAX_TAPS-1:0] tap_line;

    // two-stage code pipeline, ld stages and set applies
    always_ff @(posedge clk) begin
        if (rst) begin
            dly_pre  <= RESET_CODE;
            dly_act  <= RESET_CODE;
            fine_err <= 1'b0;
        end else begin
            if (ctl.ld) begin
                dly_pre <= clamp_fine(ctl.dly);
            end
            if (ctl.set) begin
                dly_act <= dly_pre;
            end
            // flag pulses when an out-of-range step is staged
            fine_err <= ctl.ld && (ctl.dly[2:0] >= 3'(`DESKEW_FINE_LIMIT));
        end
    end

    // during set the staged code already picks the tap
    // so the new delay shows on data_out the next cycle
    assign tap_sel = ctl.set ? code_taps(dly_pre) : code_taps(dly_act);

    // tap k is data_in delayed by k cycles, tap 0 is the live input
    assign tap_line = {shift_q, data_in};

    always_ff @(posedge clk) begin
        shift_q  <= tap_line[`DESKEW_MAX_TAPS-2:0];
        // output register adds the one fixed cycle
        data_out <= tap_line[tap_sel];
    end

endmodule

`default_nettype wire

// File: verilog/deskew_regs.sv
// axi4-lite register block for the deskew lanes: delay codes, apply/clear/enable, status
`timescale 1ns/1ps
`default_nettype none

`include "deskew_macros.svh"

module deskew_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  deskew_pkg::axil_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    input  deskew_pkg::axil_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic                   rvalid,
    input  logic                   rready,
    output deskew_pkg::dly_ctl_t   lane_ctl0,
    output deskew_pkg::dly_ctl_t   lane_ctl1,
    output logic                   cmp_en,
    output logic                   cmp_clear,
    input  deskew_pkg::cmp_stat_t  cmp_stat,
    input  logic [1:0]             fine_err
);
    import deskew_pkg::*;

    axil_wr_state_e wr_state;
    axil_rd_state_e rd_state;
    logic           wr_fire;
    logic           rd_fire;
    logic           wr_lane0;
    logic           wr_lane1;
    logic           wr_ctrl;
    dly_t           lane0_q;
    dly_t           lane1_q;
    logic           ld0_q;
    logic           ld1_q;
    logic           set_q;
    logic           clear_q;
    logic           en_q;
    logic [1:0]     fine_err_q;
    logic [31:0]    status_word;

    // aw and w taken together, only with no response pending
    assign awready = (wr_state == wr_idle) && awvalid && wvalid;
    assign wready  = awready;
    assign wr_fire = awready;
    assign bvalid  = (wr_state == wr_resp);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (wr_fire) wr_state <= wr_resp;
                wr_resp: if (bready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // unknown offsets fall through, still get a response
    assign wr_lane0 = wr_fire && (awaddr == `DESKEW_REG_LANE0);
    assign wr_lane1 = wr_fire && (awaddr == `DESKEW_REG_LANE1);
    assign wr_ctrl  = wr_fire && (awaddr == `DESKEW_REG_CTRL);

    // pulses land the cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            lane0_q <= '0;
            lane1_q <= '0;
            ld0_q   <= 1'b0;
            ld1_q   <= 1'b0;
            set_q   <= 1'b0;
            clear_q <= 1'b0;
            en_q    <= 1'b0;
        end else begin
            ld0_q   <= wr_lane0;
            ld1_q   <= wr_lane1;
            set_q   <= wr_ctrl && wdata[0];
            clear_q <= wr_ctrl && wdata[1];
            if (wr_lane0) begin
                lane0_q <= wdata[7:0];
            end
            if (wr_lane1) begin
                lane1_q <= wdata[7:0];
            end
            // compare enable is a held level
            if (wr_ctrl) begin
                en_q <= wdata[2];
            end
        end
    end

    // sticky fine errors, a new event during clear is kept
    always_ff @(posedge clk) begin
        if (rst) begin
            fine_err_q <= '0;
        end else if (clear_q) begin
            fine_err_q <= fine_err;
        end else begin
            fine_err_q <= fine_err_q | fine_err;
        end
    end

    // apply goes to both lanes at once
    assign lane_ctl0 = '{ld: ld0_q, set: set_q, dly: lane0_q};
    assign lane_ctl1 = '{ld: ld1_q, set: set_q, dly: lane1_q};
    assign cmp_en    = en_q;
    assign cmp_clear = clear_q;

    // read side, one outstanding beat
    assign arready = (rd_state == rd_idle);
    assign rd_fire = arvalid && arready;
    assign rvalid  = (rd_state == rd_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (rd_fire) rd_state <= rd_data;
                rd_data: if (rready) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // status: count, locked, then lane0/lane1 fine errors
    assign status_word = {13'b0, fine_err_q, cmp_stat.locked, cmp_stat.count};

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (araddr)
                `DESKEW_REG_LANE0:  rdata <= {24'b0, lane0_q};
                `DESKEW_REG_LANE1:  rdata <= {24'b0, lane1_q};
                `DESKEW_REG_CTRL:   rdata <= {29'b0, en_q, 2'b00};
                `DESKEW_REG_STATUS: rdata <= status_word;
                default:            rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/lane_compare.sv
// compares the two delayed lanes, counts mismatches and flags lock after a run of agreement
`timescale 1ns/1ps
`default_nettype none

`include "deskew_macros.svh"

module lane_compare (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  a,
    input  logic                  b,
    input  logic                  en,
    input  logic                  clear,
    output deskew_pkg::cmp_stat_t stat
);
    import deskew_pkg::*;

    localparam int               RUN_W   = $clog2(`DESKEW_LOCK_RUN + 1);
    localparam logic [RUN_W-1:0] RUN_MAX = RUN_W'(`DESKEW_LOCK_RUN);

    err_cnt_t         count_q;
    logic [RUN_W-1:0] run_q;
    logic [RUN_W-1:0] run_next;
    logic             locked_q;
    logic             mismatch;

    assign mismatch = a ^ b;

    // run restarts on a mismatch, parks at the lock length
    always_comb begin
        run_next = run_q;
        if (mismatch) begin
            run_next = '0;
        end else if (run_q != RUN_MAX) begin
            run_next = run_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count_q  <= '0;
            run_q    <= '0;
            locked_q <= 1'b0;
        end else if (en) begin
            // saturating count
            if (mismatch && (count_q != '1)) begin
                count_q <= count_q + 1'b1;
            end
            run_q    <= run_next;
            locked_q <= (run_next == RUN_MAX);
        end
    end

    assign stat = '{count: count_q, locked: locked_q};

endmodule

`default_nettype wire

// File: verilog/deskew_top.sv
// deskew top: axi4-lite registers, two delay lanes and the lane comparator
`timescale 1ns/1ps
`default_nettype none

module deskew_top (
    input  logic                   clk,
    input  logic                   rst,
    input  deskew_pkg::axil_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    input  deskew_pkg::axil_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic                   rvalid,
    input  logic                   rready,
    input  logic [1:0]             lane_in,
    output logic [1:0]             lane_out
);
    import deskew_pkg::*;

    dly_ctl_t   lane_ctl0;
    dly_ctl_t   lane_ctl1;
    cmp_stat_t  cmp_stat;
    logic       cmp_en;
    logic       cmp_clear;
    logic [1:0] fine_err;

    deskew_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rready    (rready),
        .lane_ctl0 (lane_ctl0),
        .lane_ctl1 (lane_ctl1),
        .cmp_en    (cmp_en),
        .cmp_clear (cmp_clear),
        .cmp_stat  (cmp_stat),
        .fine_err  (fine_err)
    );

    // both lanes start with zero taps
    idelay_fine_pipe #(.DELAY_VALUE(0)) u_lane0 (
        .clk      (clk),
        .rst      (rst),
        .ctl      (lane_ctl0),
        .data_in  (lane_in[0]),
        .data_out (lane_out[0]),
        .fine_err (fine_err[0])
    );

    idelay_fine_pipe #(.DELAY_VALUE(0)) u_lane1 (
        .clk      (clk),
        .rst      (rst),
        .ctl      (lane_ctl1),
        .data_in  (lane_in[1]),
        .data_out (lane_out[1]),
        .fine_err (fine_err[1])
    );

    // compares the delayed outputs, not the raw inputs
    lane_compare u_cmp (
        .clk   (clk),
        .rst   (rst),
        .a     (lane_out[0]),
        .b     (lane_out[1]),
        .en    (cmp_en),
        .clear (cmp_clear),
        .stat  (cmp_stat)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// clock and reset source for the deskew testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 10;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // synchronous reset, dropped on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/deskew_asserts.sv
// concurrent handshake, pulse and reset checks, bound into deskew_top by the testbench
`timescale 1ns/1ps
`default_nettype none

module deskew_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  rvalid,
    input logic                  rready,
    input deskew_pkg::dly_ctl_t  lane_ctl0,
    input deskew_pkg::dly_ctl_t  lane_ctl1,
    input deskew_pkg::cmp_stat_t cmp_stat
);
    // failures seen so far, read back by the testbench at the end
    int fail_cnt = 0;

    // write response held until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_cnt++;
        end

    // read data held until taken
    rvalid_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_cnt++;
        end

    // ld and set last one cycle on both lanes
    ctl_pulses: assert property (@(posedge clk) disable iff (rst)
        (lane_ctl0.ld || lane_ctl1.ld || lane_ctl0.set || lane_ctl1.set)
        |=> !(lane_ctl0.ld || lane_ctl1.ld || lane_ctl0.set || lane_ctl1.set))
        else begin
            $error("ld or set pulse longer than one cycle");
            fail_cnt++;
        end

    // outputs quiet right after a reset cycle
    reset_state: assert property (@(posedge clk) rst |=> !bvalid && !rvalid && !cmp_stat.locked)
        else begin
            $error("bvalid, rvalid or locked high after reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: verification/deskew_tb.sv
// testbench top for deskew_top: axi register access, lane delay model and comparator lock
`timescale 1ns/1ps
`default_nettype none

`include "deskew_macros.svh"

module deskew_tb;
    import deskew_pkg::*;

    localparam int WAIT_LIMIT    = 200;
    localparam int POLL_LIMIT    = 60;
    localparam int CLK_PERIOD_NS = 40;

    logic        clk;
    logic        rst;
    axil_addr_t  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    axil_addr_t  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [1:0]  lane_in    = 2'b00;
    logic [1:0]  lane_out;
    logic        same_input = 1'b0;
    logic [31:0] lane_rnd;

    // reference model state
    logic [1:0]  in_hist [0:255];
    dly_t        staged [2]    = '{8'h00, 8'h00};
    int          taps [2]      = '{0, 0};
    int          pend_taps [2] = '{0, 0};
    int          cyc      = 0;
    int          apply_at = -1;
    int          errors   = 0;
    int          tests    = 0;
    int          failed   = 0;
    int          test_base = 0;

    tb_clock_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    deskew_top u_deskew_top (.*);

    bind deskew_top deskew_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .bvalid    (bvalid),
        .bready    (bready),
        .rvalid    (rvalid),
        .rready    (rready),
        .lane_ctl0 (lane_ctl0),
        .lane_ctl1 (lane_ctl1),
        .cmp_stat  (cmp_stat)
    );

    // taps = coarse * 5 + fine, fine saturates at 4
    function automatic int taps_of(input dly_t code);
        int fine;
        fine = int'(code[2:0]);
        if (fine > `DESKEW_FINE_LIMIT - 1) begin
            fine = `DESKEW_FINE_LIMIT - 1;
        end
        return int'(code[7:3]) * `DESKEW_FINE_LIMIT + fine;
    endfunction

    function automatic dly_t random_code();
        logic [4:0] coarse;
        logic [2:0] fine;
        coarse = 5'($urandom_range(31, 0));
        fine   = 3'($urandom_range(`DESKEW_FINE_LIMIT - 1, 0));
        return {coarse, fine};
    endfunction

    // lane data, both lanes equal while same_input is set
    always @(posedge clk) begin
        lane_rnd = $urandom;
        lane_in <= same_input ? {2{lane_rnd[0]}} : lane_rnd[1:0];
    end

    // samples at each edge: out now equals in taken taps + 1 samples back
    always @(posedge clk) begin
        cyc = cyc + 1;
        in_hist[cyc % 256] = lane_in;
        if (cyc == apply_at) begin
            taps[0] = pend_taps[0];
            taps[1] = pend_taps[1];
        end
        for (int i = 0; i < 2; i++) begin
            if (!rst && cyc > taps[i] + 2) begin
                assert (lane_out[i] == in_hist[(cyc - 1 - taps[i]) % 256][i]) else begin
                    $display("[ERROR] %0t lane %0d out %b, expected %b with %0d taps",
                             $time, i, lane_out[i], in_hist[(cyc - 1 - taps[i]) % 256][i],
                             taps[i]);
                    errors++;
                end
            end
        end
        // accepted writes: stage on lane writes, apply two samples later
        if (awvalid && awready) begin
            case (awaddr)
                `DESKEW_REG_LANE0: staged[0] = wdata[7:0];
                `DESKEW_REG_LANE1: staged[1] = wdata[7:0];
                `DESKEW_REG_CTRL: begin
                    if (wdata[0]) begin
                        pend_taps[0] = taps_of(staged[0]);
                        pend_taps[1] = taps_of(staged[1]);
                        apply_at     = cyc + 2;
                    end
                end
                default: ;
            endcase
        end
    end

    task automatic finish_run();
        int asrt_fails;
        asrt_fails = u_deskew_top.u_asserts.fail_cnt;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests, failed, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        errors++;
        finish_run();
    endtask

    task automatic axi_write(input axil_addr_t addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(awready && wready) && n < WAIT_LIMIT);
        if (!(awready && wready)) begin
            stop_on_timeout("write address and data never accepted");
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!bvalid && n < WAIT_LIMIT);
        if (!bvalid) begin
            stop_on_timeout("write response never came");
        end
        // response waits a cycle before it is taken
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, output logic [31:0] data);
        int n;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < WAIT_LIMIT);
        if (!arready) begin
            stop_on_timeout("read address never accepted");
        end
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < WAIT_LIMIT);
        if (!rvalid) begin
            stop_on_timeout("read data never came");
        end
        data = rdata;
        // data waits a cycle before it is taken
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic expect_read(input axil_addr_t addr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        axi_read(addr, got);
        assert (got == exp) else begin
            $display("[ERROR] %0t %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_base) begin
            failed++;
            $display("test %0d %s: FAIL", tests, name);
        end else begin
            $display("test %0d %s: pass", tests, name);
        end
        test_base = errors;
    endtask

    initial begin
        int          n;
        dly_t        code;
        logic [31:0] rd_val;
        time         en_time;
        void'($urandom(32'hba4702a7));
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst && n < WAIT_LIMIT);
        if (rst) begin
            stop_on_timeout("reset never released");
        end

        // reset values, lanes at one cycle
        expect_read(`DESKEW_REG_STATUS, 32'h0, "STATUS");
        expect_read(`DESKEW_REG_LANE0, 32'h0, "LANE0");
        expect_read(`DESKEW_REG_LANE1, 32'h0, "LANE1");
        repeat (20) @(posedge clk);
        end_test("reset state");

        code = random_code();
        axi_write(`DESKEW_REG_LANE0, {24'h0, code});
        axi_write(`DESKEW_REG_CTRL, 32'h1);
        repeat (`DESKEW_MAX_TAPS + 4) @(posedge clk);
        expect_read(`DESKEW_REG_LANE0, {24'h0, code}, "LANE0");
        end_test("lane0 delay");

        // staged only, old delay stays until apply
        code = random_code();
        axi_write(`DESKEW_REG_LANE1, {24'h0, code});
        repeat (60) @(posedge clk);
        expect_read(`DESKEW_REG_LANE1, {24'h0, code}, "LANE1");
        axi_write(`DESKEW_REG_CTRL, 32'h1);
        repeat (`DESKEW_MAX_TAPS + 4) @(posedge clk);
        end_test("lane1 staged then applied");

        // fine step 6 acts as 4 and raises the lane1 flag
        code = {5'(random_code() >> 3), 3'd6};
        axi_write(`DESKEW_REG_LANE1, {24'h0, code});
        axi_write(`DESKEW_REG_CTRL, 32'h1);
        repeat (`DESKEW_MAX_TAPS + 4) @(posedge clk);
        expect_read(`DESKEW_REG_STATUS, 32'h0004_0000, "STATUS after bad fine step");
        axi_write(`DESKEW_REG_CTRL, 32'h2);
        expect_read(`DESKEW_REG_STATUS, 32'h0, "STATUS after clear");
        end_test("fine step clamp");

        // equal delays and equal data, then flush the tap lines
        same_input <= 1'b1;
        code = random_code();
        axi_write(`DESKEW_REG_LANE0, {24'h0, code});
        axi_write(`DESKEW_REG_LANE1, {24'h0, code});
        axi_write(`DESKEW_REG_CTRL, 32'h1);
        repeat (`DESKEW_MAX_TAPS + 4) @(posedge clk);
        axi_write(`DESKEW_REG_CTRL, 32'h6);
        en_time = $time;
        n = 0;
        do begin
            axi_read(`DESKEW_REG_STATUS, rd_val);
            n++;
        end while (!rd_val[16] && n < POLL_LIMIT);
        if (!rd_val[16]) begin
            stop_on_timeout("comparator never locked");
        end else begin
            assert (rd_val == 32'h0001_0000) else begin
                $display("[ERROR] %0t STATUS at lock %h, expected 00010000", $time, rd_val);
                errors++;
            end
            // lock needs a full run of agreeing cycles after enable
            assert (($time - en_time) >= `DESKEW_LOCK_RUN * CLK_PERIOD_NS) else begin
                $display("[ERROR] %0t locked %0t after enable, expected at least %0d cycles",
                         $time, $time - en_time, `DESKEW_LOCK_RUN);
                errors++;
            end
        end
        // one coarse tap apart on lane1, independent data
        axi_write(`DESKEW_REG_LANE1, {24'h0, code[7:3] ^ 5'd1, code[2:0]});
        axi_write(`DESKEW_REG_CTRL, 32'h5);
        same_input <= 1'b0;
        n = 0;
        do begin
            axi_read(`DESKEW_REG_STATUS, rd_val);
            n++;
        end while (rd_val[15:0] < 16'd8 && n < POLL_LIMIT);
        if (rd_val[15:0] < 16'd8) begin
            stop_on_timeout("mismatch count never grew");
        end else begin
            assert (!rd_val[16]) else begin
                $display("[ERROR] %0t locked still high with count %0d", $time, rd_val[15:0]);
                errors++;
            end
        end
        axi_write(`DESKEW_REG_CTRL, 32'h2);
        expect_read(`DESKEW_REG_STATUS, 32'h0, "STATUS after compare clear");
        end_test("compare and lock");

        finish_run();
    end

endmodule

`default_nettype wire

// File: deskew.f
+incdir+verilog
verilog/deskew_pkg.sv
verilog/idelay_fine_pipe.sv
verilog/deskew_regs.sv
verilog/lane_compare.sv
verilog/deskew_top.sv
verification/tb_clock_gen.sv
verification/deskew_asserts.sv
verification/deskew_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the deskew testbench with verilator, then check the log
verilator --binary --assert -Wno-fatal -f deskew.f --top-module deskew_tb -o sim_deskew || exit 1
./obj_dir/sim_deskew +verilator+error+limit+100 > sim.log 2>&1 || echo "simulation exited abnormally" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
